// File: tb.f
+incdir+common
common/fp_pkg.sv
common/bfu_pkg.sv
design/fp_add.sv
design/fp_mul.sv
bfu/cplx_mul.sv
bfu/bfu_pre.sv
bfu/bfu_post.sv
design/bfu_top.sv
verif/tb_bfu.sv

// File: Bender.yml
package:
  name: bfu

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/fp_pkg.sv
      - common/bfu_pkg.sv
      - design/fp_add.sv
      - design/fp_mul.sv
      - bfu/cplx_mul.sv
      - bfu/bfu_pre.sv
      - bfu/bfu_post.sv
      - design/bfu_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - verif/tb_bfu.sv

// File: verif/tb_bfu.sv
`timescale 1ns/1ps
`include "fp_macros.svh"

module tb_bfu;
    import fp_pkg::*;
    import bfu_pkg::*;

    localparam int NT = 14;                  // table rows

    logic      clk, arst_n, en, out_valid;
    bfu_mode_e mode;
    fp64_t     a_re, a_im, b_re, b_im, c_re, c_im;
    fp64_t     o_a_re, o_a_im, o_b_re, o_b_im;

    // stimulus table, one operand set per row
    bfu_mode_e t_mode [NT];
    real       t_ar [NT], t_ai [NT], t_br [NT], t_bi [NT], t_cr [NT], t_ci [NT];
    int        t_gap [NT];                   // idle cycles after the set

    logic [4*`FP_W-1:0] exp_q [$];           // o_a_re, o_a_im, o_b_re, o_b_im
    int                 due_q [$];           // cycle in which out_valid is due
    logic [4*`FP_W-1:0] got_exp;
    logic               want_valid;
    int cyc = 0;
    int errors = 0, n_checks = 0, n_tests = 0, n_failed = 0, n_out = 0;
    integer seed = 32'h3c26_e078;

    bfu_top UUT (
        .clk(clk), .arst_n(arst_n), .en(en), .mode(mode),
        .a_re(a_re), .a_im(a_im), .b_re(b_re), .b_im(b_im), .c_re(c_re), .c_im(c_im),
        .out_valid(out_valid),
        .o_a_re(o_a_re), .o_a_im(o_a_im), .o_b_re(o_b_re), .o_b_im(o_b_im)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;              // 100 ns period
    end

    always @(posedge clk)
        cyc <= cyc + 1;

    //////////////////////////////////////////////////
    // reference model in real arithmetic
    function automatic real rezero(input real r);
        return (r == 0.0) ? 0.0 : r;         // a zero of either sign becomes +0
    endfunction

    function automatic logic [4*`FP_W-1:0] model(input bfu_mode_e m,
            input fp64_t ar, ai, br, bi, cr, ci);
        real a_r, a_i, b_r, b_i, w_r, w_i, x_r, x_i, y_r, y_i, t_r, t_i;
        a_r = $bitstoreal(ar);
        a_i = $bitstoreal(ai);
        b_r = $bitstoreal(br);
        b_i = $bitstoreal(bi);
        y_r = $bitstoreal(cr);
        y_i = $bitstoreal(ci);
        if (m == BFU_IFFT) begin
            w_r = rezero(a_r + b_r);
            w_i = rezero(a_i + b_i);
            x_r = rezero(a_r - b_r);
            x_i = rezero(a_i - b_i);
            y_i = -y_i;                      // conj(c)
        end else begin
            w_r = a_r;
            w_i = a_i;
            x_r = b_r;
            x_i = b_i;
        end
        t_r = rezero(rezero(x_r * y_r) - rezero(x_i * y_i));  // one rounding per op
        t_i = rezero(rezero(x_r * y_i) + rezero(x_i * y_r));
        if (m == BFU_IFFT)
            return {$realtobits(w_r / 2.0), $realtobits(w_i / 2.0),
                    $realtobits(t_r / 2.0), $realtobits(t_i / 2.0)};
        else
            return {$realtobits(rezero(w_r + t_r)), $realtobits(rezero(w_i + t_i)),
                    $realtobits(rezero(w_r - t_r)), $realtobits(rezero(w_i - t_i))};
    endfunction

    //////////////////////////////////////////////////
    // compare tasks
    task automatic compare_word(input string name, input fp64_t got, input fp64_t want);
        n_checks++;
        if (got !== want) begin
            $display("FAILED at %0t: %s = %h, expected %h", $time, name, got, want);
            errors++;
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic want);
        n_checks++;
        if (got !== want) begin
            $display("FAILED at %0t: %s = %b, expected %b", $time, name, got, want);
            errors++;
        end
    endtask

    // outputs are stable on the falling edge
    always @(negedge clk) begin
        if (en === 1'b1 && arst_n === 1'b1)
            due_q.push_back(cyc + `BFU_LAT);
        want_valid = (due_q.size() > 0) && (due_q[0] == cyc);
        compare_bit("out_valid", out_valid, want_valid);
        if (out_valid === 1'b1)
            n_out++;
        if (want_valid) begin
            void'(due_q.pop_front());
            got_exp = exp_q.pop_front();
            compare_word("o_a_re", o_a_re, got_exp[4*`FP_W-1 -: `FP_W]);
            compare_word("o_a_im", o_a_im, got_exp[3*`FP_W-1 -: `FP_W]);
            compare_word("o_b_re", o_b_re, got_exp[2*`FP_W-1 -: `FP_W]);
            compare_word("o_b_im", o_b_im, got_exp[`FP_W-1:0]);
        end
    end

    //////////////////////////////////////////////////
    // driving
    task automatic apply(input bfu_mode_e m, input fp64_t ar, ai, br, bi, cr, ci);
        @(posedge clk);
        en   <= 1'b1;
        mode <= m;
        a_re <= ar;
        a_im <= ai;
        b_re <= br;
        b_im <= bi;
        c_re <= cr;
        c_im <= ci;
        exp_q.push_back(model(m, ar, ai, br, bi, cr, ci));
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            en <= 1'b0;
        end
    endtask

    // wait until every set in flight has come out
    task automatic drain();
        int n;
        n = 0;
        while (due_q.size() != 0 && n < 4 * `BFU_LAT) begin
            @(posedge clk);
            n++;
        end
        if (due_q.size() != 0) begin
            $display("timeout: %0d set(s) never showed up on out_valid", due_q.size());
            errors++;
            due_q.delete();
            exp_q.delete();
        end
    endtask

    task automatic set_row(input int i, input bfu_mode_e m,
            input real ar, ai, br, bi, cr, ci, input int gap);
        t_mode[i] = m;
        t_ar[i]   = ar;
        t_ai[i]   = ai;
        t_br[i]   = br;
        t_bi[i]   = bi;
        t_cr[i]   = cr;
        t_ci[i]   = ci;
        t_gap[i]  = gap;
    endtask

    task automatic load_table();
        set_row(0,  BFU_FFT,  1.5, -2.25, 0.75, 0.5, 1.0, 0.0, 3);        // c = 1
        set_row(1,  BFU_FFT,  3.0, 1.0, 0.0, 0.0, 0.7071067811865476, -0.7071067811865476, 2);
        set_row(2,  BFU_FFT,  -0.125, 4.5, 2.0, -3.0, 0.3826834323650898, 0.9238795325112867, 0);
        set_row(3,  BFU_FFT,  100.25, -7.5, -1.1, 2.2, 0.9238795325112867, -0.3826834323650898, 5);
        set_row(4,  BFU_FFT,  1.0, 1.0, 1.0, 1.0, 0.0, 1.0, 1);           // exact zero sum
        set_row(5,  BFU_IFFT, 2.0, -1.0, 0.5, 0.25, 0.7071067811865476, 0.7071067811865476, 2);
        set_row(6,  BFU_IFFT, 1.25, 3.5, 1.25, 3.5, 0.3826834323650898, -0.9238795325112867, 4);
        set_row(7,  BFU_IFFT, -6.0, 0.1, 3.3, -2.7, 1.0, 0.0, 0);
        set_row(8,  BFU_IFFT, 0.001, 1000.0, -0.002, 500.0, -0.5, 0.8660254037844386, 3);
        // mixed modes, en high every cycle
        set_row(9,  BFU_FFT,  2.5, -0.5, 1.5, 0.25, 0.5, 0.8660254037844386, 0);
        set_row(10, BFU_IFFT, -3.0, 2.0, 1.0, -1.0, 0.9238795325112867, 0.3826834323650898, 0);
        set_row(11, BFU_FFT,  0.0, 0.0, -2.0, 4.0, -0.7071067811865476, 0.7071067811865476, 0);
        set_row(12, BFU_IFFT, 7.75, -1.25, -0.25, 0.125, 0.0, -1.0, 0);
        set_row(13, BFU_FFT,  1000.0, -0.001, 3.14159, 2.71828, 0.1, 0.2, 0);
    endtask

    task automatic run_rows(input int first, input int count);
        for (int i = first; i < first + count; i++) begin
            apply(t_mode[i], $realtobits(t_ar[i]), $realtobits(t_ai[i]), $realtobits(t_br[i]),
                  $realtobits(t_bi[i]), $realtobits(t_cr[i]), $realtobits(t_ci[i]));
            idle(t_gap[i]);
        end
        idle(1);
        drain();
    endtask

    // random normal operand, exponent within 20 of the bias
    function automatic fp64_t rand_operand();
        integer      e;
        logic [31:0] hi, lo, s;
        e  = `EXP_BIAS + ($random(seed) % 21);
        hi = $random(seed);
        lo = $random(seed);
        s  = $random(seed);
        return {s[0], e[`EXP_W-1:0], hi[19:0], lo};
    endfunction

    task automatic end_test(input string name, input int e0);
        n_tests++;
        if (errors == e0) begin
            $display("test %0d (%s): ok", n_tests, name);
        end else begin
            n_failed++;
            $display("test %0d (%s): %0d error(s)", n_tests, name, errors - e0);
        end
    endtask

    //////////////////////////////////////////////////
    // test sequence
    initial begin
        int        e0, o0;
        integer    r;
        bfu_mode_e m;
        en     = 1'b0;
        mode   = BFU_FFT;
        {a_re, a_im, b_re, b_im, c_re, c_im} = '0;
        arst_n = 1'b0;
        load_table();
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;

        e0 = errors;
        repeat (20) @(posedge clk);          // monitor expects out_valid low throughout
        end_test("idle after reset", e0);

        e0 = errors;
        run_rows(0, 5);
        end_test("fft table", e0);

        e0 = errors;
        run_rows(5, 4);
        end_test("ifft table", e0);

        e0 = errors;
        run_rows(9, 5);
        end_test("mixed back-to-back", e0);

        e0 = errors;
        o0 = n_out;
        for (int k = 0; k < 40; k++) begin
            r = $random(seed);
            m = bfu_mode_e'(r[0]);
            apply(m, rand_operand(), rand_operand(), rand_operand(),
                  rand_operand(), rand_operand(), rand_operand());
            r = $random(seed);
            idle(r[1:0]);                    // 0..3 idle cycles
        end
        idle(1);
        drain();
        if (n_out - o0 != 40) begin
            $display("out_valid pulsed %0d times for 40 random sets", n_out - o0);
            errors++;
        end
        end_test("random sets", e0);

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 n_tests, n_failed, n_checks, errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: design/bfu_top.sv
`timescale 1ns/1ps

module bfu_top (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               en,        // one operand set per high cycle
    input  bfu_pkg::bfu_mode_e mode,
    input  fp_pkg::fp64_t      a_re,
    input  fp_pkg::fp64_t      a_im,
    input  fp_pkg::fp64_t      b_re,
    input  fp_pkg::fp64_t      b_im,
    input  fp_pkg::fp64_t      c_re,
    input  fp_pkg::fp64_t      c_im,
    output logic               out_valid,
    output fp_pkg::fp64_t      o_a_re,
    output fp_pkg::fp64_t      o_a_im,
    output fp_pkg::fp64_t      o_b_re,
    output fp_pkg::fp64_t      o_b_im
);
    import fp_pkg::*;
    import bfu_pkg::*;

    logic      pre_valid;
    bfu_mode_e pre_mode;
    fp64_t     w_re, w_im;                // bypass operand for post
    fp64_t     x_re, x_im, y_re, y_im;    // multiplier operands
    fp64_t     t_re, t_im;                // product

    bfu_pre u_pre (
        .clk(clk), .arst_n(arst_n), .en(en), .mode(mode),
        .a_re(a_re), .a_im(a_im), .b_re(b_re), .b_im(b_im), .c_re(c_re), .c_im(c_im),
        .valid_q(pre_valid), .mode_q(pre_mode),
        .w_re(w_re), .w_im(w_im), .x_re(x_re), .x_im(x_im), .y_re(y_re), .y_im(y_im)
    );

    cplx_mul u_cmul (
        .clk(clk), .arst_n(arst_n),
        .x_re(x_re), .x_im(x_im), .y_re(y_re), .y_im(y_im),
        .t_re(t_re), .t_im(t_im)
    );

    bfu_post u_post (
        .clk(clk), .arst_n(arst_n), .valid_d(pre_valid), .mode_d(pre_mode),
        .w_re(w_re), .w_im(w_im), .t_re(t_re), .t_im(t_im),
        .out_valid(out_valid),
        .o_a_re(o_a_re), .o_a_im(o_a_im), .o_b_re(o_b_re), .o_b_im(o_b_im)
    );

endmodule

// File: bfu/bfu_post.sv
`timescale 1ns/1ps
`include "fp_macros.svh"

module bfu_post (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               valid_d,
    input  bfu_pkg::bfu_mode_e mode_d,
    input  fp_pkg::fp64_t      w_re,
    input  fp_pkg::fp64_t      w_im,
    input  fp_pkg::fp64_t      t_re,
    input  fp_pkg::fp64_t      t_im,
    output logic               out_valid,
    output fp_pkg::fp64_t      o_a_re,
    output fp_pkg::fp64_t      o_a_im,
    output fp_pkg::fp64_t      o_b_re,
    output fp_pkg::fp64_t      o_b_im
);
    import fp_pkg::*;
    import bfu_pkg::*;

    localparam int VL = `CMUL_LAT + `ADD_LAT;  // whole stage depth

    // divide by two through the exponent, tiny results flush to +0
    function automatic fp64_t halve(input fp64_t x);
        fp64_u u;
        u.raw = x;
        if (u.f.exponent <= 1)
            u.raw = '0;
        else
            u.f.exponent = u.f.exponent - 1'b1;
        return u.raw;
    endfunction

    fp64_t w_re_al, w_im_al;                  // w lined up with t
    fp64_t sum_re, sum_im, dif_re, dif_im;
    fp64_t h_a_re, h_a_im, h_b_re, h_b_im;    // halved IFFT results

    logic [2*`FP_W-1:0] w_dly   [`CMUL_LAT];
    logic [4*`FP_W-1:0] h_dly   [`ADD_LAT];
    bfu_mode_e          mode_dly [VL];
    logic [VL-1:0]      vld_dly;

    //////////////////////////////////////////////////
    // wait for the complex product
    always_ff @(posedge clk) begin
        w_dly[0] <= {w_re, w_im};
        for (int i = 1; i < `CMUL_LAT; i++)
            w_dly[i] <= w_dly[i-1];
    end

    assign {w_re_al, w_im_al} = w_dly[`CMUL_LAT-1];

    // mode and valid cover the multiply and the final add
    always_ff @(posedge clk) begin
        mode_dly[0] <= mode_d;
        for (int i = 1; i < VL; i++)
            mode_dly[i] <= mode_dly[i-1];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            vld_dly <= '0;
        else
            vld_dly <= {vld_dly[VL-2:0], valid_d};
    end

    //////////////////////////////////////////////////
    // FFT path w+t and w-t
    fp_add u_add_re (.clk(clk), .arst_n(arst_n), .a(w_re_al), .b(t_re), .sub(1'b0), .z(sum_re));
    fp_add u_add_im (.clk(clk), .arst_n(arst_n), .a(w_im_al), .b(t_im), .sub(1'b0), .z(sum_im));
    fp_add u_sub_re (.clk(clk), .arst_n(arst_n), .a(w_re_al), .b(t_re), .sub(1'b1), .z(dif_re));
    fp_add u_sub_im (.clk(clk), .arst_n(arst_n), .a(w_im_al), .b(t_im), .sub(1'b1), .z(dif_im));

    // IFFT path, halve now and match the adder delay
    always_ff @(posedge clk) begin
        h_dly[0] <= {halve(w_re_al), halve(w_im_al), halve(t_re), halve(t_im)};
        for (int i = 1; i < `ADD_LAT; i++)
            h_dly[i] <= h_dly[i-1];
    end

    assign {h_a_re, h_a_im, h_b_re, h_b_im} = h_dly[`ADD_LAT-1];

    assign out_valid = vld_dly[VL-1];

    assign o_a_re = (mode_dly[VL-1] == BFU_IFFT) ? h_a_re : sum_re;
    assign o_a_im = (mode_dly[VL-1] == BFU_IFFT) ? h_a_im : sum_im;
    assign o_b_re = (mode_dly[VL-1] == BFU_IFFT) ? h_b_re : dif_re;
    assign o_b_im = (mode_dly[VL-1] == BFU_IFFT) ? h_b_im : dif_im;

endmodule

// File: bfu/bfu_pre.sv
`timescale 1ns/1ps
`include "fp_macros.svh"

module bfu_pre (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               en,
    input  bfu_pkg::bfu_mode_e mode,
    input  fp_pkg::fp64_t      a_re,
    input  fp_pkg::fp64_t      a_im,
    input  fp_pkg::fp64_t      b_re,
    input  fp_pkg::fp64_t      b_im,
    input  fp_pkg::fp64_t      c_re,
    input  fp_pkg::fp64_t      c_im,
    output logic               valid_q,
    output bfu_pkg::bfu_mode_e mode_q,
    output fp_pkg::fp64_t      w_re,
    output fp_pkg::fp64_t      w_im,
    output fp_pkg::fp64_t      x_re,
    output fp_pkg::fp64_t      x_im,
    output fp_pkg::fp64_t      y_re,
    output fp_pkg::fp64_t      y_im
);
    import fp_pkg::*;
    import bfu_pkg::*;

    fp64_t sum_re, sum_im, dif_re, dif_im;      // a+b and a-b, used by IFFT
    fp64_t a_re_d, a_im_d, b_re_d, b_im_d, c_re_d, c_im_d;

    logic [6*`FP_W-1:0]  pass_d [`ADD_LAT];      // FFT bypass, matches adder depth
    bfu_mode_e           mode_d [`ADD_LAT];
    logic [`ADD_LAT-1:0] en_d;

    fp_add u_add_re (.clk(clk), .arst_n(arst_n), .a(a_re), .b(b_re), .sub(1'b0), .z(sum_re));
    fp_add u_add_im (.clk(clk), .arst_n(arst_n), .a(a_im), .b(b_im), .sub(1'b0), .z(sum_im));
    fp_add u_sub_re (.clk(clk), .arst_n(arst_n), .a(a_re), .b(b_re), .sub(1'b1), .z(dif_re));
    fp_add u_sub_im (.clk(clk), .arst_n(arst_n), .a(a_im), .b(b_im), .sub(1'b1), .z(dif_im));

    //////////////////////////////////////////////////
    // operand and mode delay lines
    always_ff @(posedge clk) begin
        pass_d[0] <= {a_re, a_im, b_re, b_im, c_re, c_im};
        mode_d[0] <= mode;
        for (int i = 1; i < `ADD_LAT; i++) begin
            pass_d[i] <= pass_d[i-1];
            mode_d[i] <= mode_d[i-1];
        end
    end

    // valid chain
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            en_d <= '0;
        else
            en_d <= {en_d[`ADD_LAT-2:0], en};
    end

    assign {a_re_d, a_im_d, b_re_d, b_im_d, c_re_d, c_im_d} = pass_d[`ADD_LAT-1];

    assign valid_q = en_d[`ADD_LAT-1];
    assign mode_q  = mode_d[`ADD_LAT-1];

    //////////////////////////////////////////////////
    // per-set select, mode travels with its data
    assign w_re = (mode_q == BFU_IFFT) ? sum_re : a_re_d;
    assign w_im = (mode_q == BFU_IFFT) ? sum_im : a_im_d;
    assign x_re = (mode_q == BFU_IFFT) ? dif_re : b_re_d;
    assign x_im = (mode_q == BFU_IFFT) ? dif_im : b_im_d;
    assign y_re = c_re_d;
    assign y_im = (mode_q == BFU_IFFT) ? {~c_im_d[`FP_W-1], c_im_d[`FP_W-2:0]}  // conj(c)
                                       : c_im_d;

endmodule

// File: bfu/cplx_mul.sv
`timescale 1ns/1ps

module cplx_mul (
    input  logic          clk,
    input  logic          arst_n,
    input  fp_pkg::fp64_t x_re,
    input  fp_pkg::fp64_t x_im,
    input  fp_pkg::fp64_t y_re,
    input  fp_pkg::fp64_t y_im,
    output fp_pkg::fp64_t t_re,
    output fp_pkg::fp64_t t_im
);
    import fp_pkg::*;

    // partial products, all four in parallel
    fp64_t p_rr;  // x_re * y_re
    fp64_t p_ii;  // x_im * y_im
    fp64_t p_ri;  // x_re * y_im
    fp64_t p_ir;  // x_im * y_re

    fp_mul u_mul_rr (.clk(clk), .arst_n(arst_n), .a(x_re), .b(y_re), .z(p_rr));
    fp_mul u_mul_ii (.clk(clk), .arst_n(arst_n), .a(x_im), .b(y_im), .z(p_ii));
    fp_mul u_mul_ri (.clk(clk), .arst_n(arst_n), .a(x_re), .b(y_im), .z(p_ri));
    fp_mul u_mul_ir (.clk(clk), .arst_n(arst_n), .a(x_im), .b(y_re), .z(p_ir));

    // real part subtracts, imaginary part adds
    fp_add u_add_re (
        .clk    (clk),
        .arst_n (arst_n),
        .a      (p_rr),
        .b      (p_ii),
        .sub    (1'b1),
        .z      (t_re)
    );

    fp_add u_add_im (
        .clk    (clk),
        .arst_n (arst_n),
        .a      (p_ri),
        .b      (p_ir),
        .sub    (1'b0),
        .z      (t_im)
    );

endmodule

// File: design/fp_mul.sv
`timescale 1ns/1ps
`include "fp_macros.svh"

module fp_mul (
    input  logic          clk,
    input  logic          arst_n,
    input  fp_pkg::fp64_t a,
    input  fp_pkg::fp64_t b,
    output fp_pkg::fp64_t z
);
    import fp_pkg::*;

    localparam int MW   = `MAN_W + 1;      // with hidden one
    localparam int PW   = 2 * MW;          // full product width
    localparam int EW   = `EXP_W + 2;      // room for sign and carry
    localparam int BIAS = `EXP_BIAS;

    fp64_u ua, ub;

    always_comb begin
        ua.raw = a;
        ub.raw = b;
    end

    //////////////////////////////////////////////////
    // stage 1 sign, exponent sum, mantissa product
    logic                 s1_zero;          // either operand zero or subnormal
    logic                 s1_sign;
    logic signed [EW-1:0] s1_exp;           // unbiased sum, bias added back once
    logic [PW-1:0]        s1_prod;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            s1_zero <= 1'b1;
        else
            s1_zero <= (ua.f.exponent == '0) || (ub.f.exponent == '0);
    end

    always_ff @(posedge clk) begin
        s1_sign <= ua.f.sign ^ ub.f.sign;
        s1_exp  <= EW'(ua.f.exponent) + EW'(ub.f.exponent) - EW'(BIAS);
        s1_prod <= {1'b1, ua.f.fraction} * {1'b1, ub.f.fraction};
    end

    //////////////////////////////////////////////////
    // stage 2 one-bit normalize and round
    logic [MW-1:0]        man;
    logic                 grd, rnd, stk;
    logic signed [EW-1:0] exp_n;
    logic                 rnd_up;
    logic [MW:0]          man_r;
    fp64_u                res;

    always_comb begin
        if (s1_prod[PW-1]) begin                // product in [2,4)
            man   = s1_prod[PW-1 -: MW];
            grd   = s1_prod[PW-MW-1];
            rnd   = s1_prod[PW-MW-2];
            stk   = |s1_prod[PW-MW-3:0];
            exp_n = s1_exp + 13'sd1;
        end else begin                          // product in [1,2)
            man   = s1_prod[PW-2 -: MW];
            grd   = s1_prod[PW-MW-2];
            rnd   = s1_prod[PW-MW-3];
            stk   = |s1_prod[PW-MW-4:0];
            exp_n = s1_exp;
        end
        rnd_up = grd & (rnd | stk | man[0]);     // ties go to even
        man_r  = {1'b0, man} + (MW+1)'(rnd_up);
        res.f.sign     = s1_sign;
        res.f.exponent = exp_n[`EXP_W-1:0] + {{(`EXP_W-1){1'b0}}, man_r[MW]};
        res.f.fraction = man_r[MW] ? man_r[MW-1:1] : man_r[MW-2:0];
        if (s1_zero || exp_n < 13'sd1)
            res.raw = '0;                       // flush to +0
    end

    always_ff @(posedge clk)
        z <= res.raw;

endmodule

// File: design/fp_add.sv
`timescale 1ns/1ps
`include "fp_macros.svh"

module fp_add (
    input  logic          clk,
    input  logic          arst_n,
    input  fp_pkg::fp64_t a,
    input  fp_pkg::fp64_t b,
    input  logic          sub,     // high gives a - b
    output fp_pkg::fp64_t z
);
    import fp_pkg::*;

    localparam int MW = `MAN_W + 1;  // mantissa incl hidden one
    localparam int AW = MW + 3;      // plus guard, round, sticky

    // number of zeros above the leading one
    function automatic logic [5:0] lzc(input logic [AW-1:0] v);
        logic [5:0] n;
        logic       found;
        n     = '0;
        found = 1'b0;
        for (int i = AW - 1; i >= 0; i--) begin
            if (!found && !v[i])
                n = n + 6'd1;
            else
                found = 1'b1;
        end
        return n;
    endfunction

    //////////////////////////////////////////////////
    // stage 1 decode, order by magnitude, align
    fp64_u             ua, ub;
    logic              a_zero, b_zero;
    logic              b_sign;              // sign of b after the sub flip
    logic [`FP_W-2:0]  a_mag, b_mag;        // exponent and fraction as one key
    logic              swap;
    logic [MW-1:0]     a_man, b_man, l_man, s_man;
    logic [`EXP_W-1:0] l_exp, diff;
    logic [AW-1:0]     s_ext, s_al, lost_mask;

    always_comb begin
        ua.raw = a;
        ub.raw = b;
        a_zero = (ua.f.exponent == '0);    // subnormal counts as zero
        b_zero = (ub.f.exponent == '0);
        b_sign = ub.f.sign ^ sub;
        a_man  = a_zero ? '0 : {1'b1, ua.f.fraction};
        b_man  = b_zero ? '0 : {1'b1, ub.f.fraction};
        a_mag  = a_zero ? '0 : {ua.f.exponent, ua.f.fraction};
        b_mag  = b_zero ? '0 : {ub.f.exponent, ub.f.fraction};
        swap   = (b_mag > a_mag);          // larger operand goes first
        l_man  = swap ? b_man : a_man;
        s_man  = swap ? a_man : b_man;
        l_exp  = swap ? ub.f.exponent : ua.f.exponent;
        diff   = l_exp - (swap ? ua.f.exponent : ub.f.exponent);
        s_ext  = {s_man, 3'b000};
        lost_mask = '0;
        if (diff >= AW) begin
            s_al = {{(AW-1){1'b0}}, |s_man};  // everything lands in sticky
        end else begin
            lost_mask = (AW'(1) << diff) - AW'(1);
            s_al      = s_ext >> diff;
            s_al[0]   = s_al[0] | (|(s_ext & lost_mask));
        end
    end

    logic              s1_sign;
    logic              s1_sub;              // effective subtraction
    logic [`EXP_W-1:0] s1_exp;
    logic [AW-1:0]     s1_l, s1_s;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            s1_sub <= 1'b0;
        else
            s1_sub <= ua.f.sign ^ b_sign;
    end

    always_ff @(posedge clk) begin
        s1_sign <= swap ? b_sign : ua.f.sign;
        s1_exp  <= l_exp;
        s1_l    <= {l_man, 3'b000};
        s1_s    <= s_al;
    end

    //////////////////////////////////////////////////
    // stage 2 add, normalize, round, pack
    logic [AW:0]              sum;        // extra carry bit
    logic [5:0]               lz;
    logic [AW-1:0]            norm;       // leading one at msb
    logic signed [`EXP_W+1:0] exp_n;
    logic                     rnd_up;
    logic [MW:0]              man_r;      // msb set on rounding carry
    fp64_u                    res;

    always_comb begin
        if (s1_sub)
            sum = {1'b0, s1_l} - {1'b0, s1_s};  // never negative after the swap
        else
            sum = {1'b0, s1_l} + {1'b0, s1_s};
        lz = lzc(sum[AW-1:0]);
        if (sum[AW]) begin
            norm    = sum[AW:1];               // carry out, shift right once
            norm[0] = norm[0] | sum[0];
            exp_n   = $signed({2'b00, s1_exp}) + 13'sd1;
        end else begin
            norm  = sum[AW-1:0] << lz;
            exp_n = $signed({2'b00, s1_exp}) - $signed({7'b0, lz});
        end
        rnd_up = norm[2] & (norm[1] | norm[0] | norm[3]);  // nearest even
        man_r  = {1'b0, norm[AW-1:3]} + (MW+1)'(rnd_up);
        res.f.sign     = s1_sign;
        res.f.exponent = exp_n[`EXP_W-1:0] + {{(`EXP_W-1){1'b0}}, man_r[MW]};
        res.f.fraction = man_r[MW] ? man_r[MW-1:1] : man_r[MW-2:0];
        if (sum == '0 || exp_n < 13'sd1)
            res.raw = '0;                      // exact zero or underflow gives +0
    end

    always_ff @(posedge clk)
        z <= res.raw;

endmodule

// File: common/bfu_pkg.sv
package bfu_pkg;

    // butterfly flavour, sampled with every operand set
    typedef enum logic {
        BFU_FFT  = 1'b0,  // cooley-tukey, a+bc / a-bc
        BFU_IFFT = 1'b1   // gentleman-sande, (a+b)/2 / (a-b)conj(c)/2
    } bfu_mode_e;

endpackage

// File: common/fp_pkg.sv
`include "fp_macros.svh"

package fp_pkg;

    // plain word as carried on every data port
    typedef logic [`FP_W-1:0] fp64_t;

    // IEEE-754 binary64 fields, msb first
    typedef struct packed {
        logic              sign;      // 1 = negative
        logic [`EXP_W-1:0] exponent;  // biased, 0 is treated as zero
        logic [`MAN_W-1:0] fraction;  // hidden one is implied
    } fp64_fields_t;

    // same 64 bits seen as a port word or as decoded fields
    typedef union packed {
        fp64_t        raw;
        fp64_fields_t f;
    } fp64_u;

endpackage

// File: common/fp_macros.svh
`ifndef FP_MACROS_SVH
`define FP_MACROS_SVH

// binary64 word layout
`define FP_W      64      // full word
`define EXP_W     11      // biased exponent field
`define MAN_W     52      // stored fraction, hidden bit not included
`define EXP_BIAS  1023

// pipeline depths in clock cycles
`define ADD_LAT   2       // fp_add
`define MUL_LAT   2       // fp_mul
`define CMUL_LAT  4       // one multiply then one add
`define BFU_LAT   8       // pre + complex multiply + post

`endif
